// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;

    // primary opcode, bits 31:26.
    typedef enum logic [5:0] {
        OP_RT     = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
        OP_BEQ    = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
        OP_ADDI   = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI   = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
        OP_LB     = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
        OP_LHU    = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
    } op_t;

    // r-type function, bits 5:0.
    typedef enum logic [5:0] {
        F_SLL  = 6'h00, F_SRL  = 6'h02, F_SRA  = 6'h03, F_SLLV = 6'h04,
        F_SRLV = 6'h06, F_SRAV = 6'h07, F_JR   = 6'h08, F_JALR = 6'h09,
        F_ADD  = 6'h20, F_ADDU = 6'h21, F_SUB  = 6'h22, F_SUBU = 6'h23,
        F_AND  = 6'h24, F_OR   = 6'h25, F_XOR  = 6'h26, F_NOR  = 6'h27,
        F_SLT  = 6'h2a, F_SLTU = 6'h2b
    } func_t;

    // regimm selector in the rt field.
    typedef enum logic [4:0] {
        B_BLTZ   = 5'h00,
        B_BGEZ   = 5'h01,
        B_BLTZAL = 5'h10,
        B_BGEZAL = 5'h11
    } regimm_t;

    typedef enum logic [5:0] {
        ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ,
        J, JAL, JR, JALR,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        RESERVED
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASSA
    } alufunc_t;

endpackage

`default_nettype wire

// ==== src/dcu_pkg.sv ====
`default_nettype none

package dcu_pkg;

    import isa_pkg::*;

    typedef enum logic {RT, RD} regdst_t;
    typedef enum logic {REGB, IMM} alusrc_t;

    typedef enum logic [2:0] {
        T_BEQ, T_BNE, T_BGEZ, T_BLTZ, T_BGTZ, T_BLEZ
    } branch_t;

    typedef struct packed {
        alufunc_t alufunc;
        logic     regwrite;
        regdst_t  regdst;
        alusrc_t  alusrc;
        logic     memtoreg;
        logic     memwrite;
        logic     branch;
        branch_t  branch_type;
        logic     jump;
        logic     jr;
        logic     zeroext;
        logic     shamt_valid;
    } control_t;

    typedef struct packed {
        decoded_op_t op;
        control_t    ctl;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        word_t       imm;
    } decoded_instr_t;

    // apb register map.
    localparam logic [3:0] REG_INSTR    = 4'h0;
    localparam logic [3:0] REG_STATUS   = 4'h4;
    localparam logic [3:0] REG_RI_COUNT = 4'h8;

endpackage

`default_nettype wire

// ==== src/dec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dec_if
    import dcu_pkg::*;
();
    logic           valid;
    logic           ready;
    decoded_instr_t instr;
    logic           ri;

    modport source (output valid, output instr, output ri, input ready);
    modport sink (input valid, input instr, input ri, output ready);

endinterface

`default_nettype wire

// ==== src/apb_instr_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_instr_port
    import isa_pkg::*;
    import dcu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        in_valid,
    input  logic        in_ready,
    output word_t       in_word,
    input  logic        ri_pop,
    input  logic        queue_nonempty
);
    logic        access;
    logic        mapped;
    logic        instr_wr;
    logic        count_clr;
    logic        hold_full;
    word_t       hold_word;
    logic [31:0] ri_count;

    assign access  = psel && penable;
    assign mapped  = (paddr == REG_INSTR) || (paddr == REG_STATUS) || (paddr == REG_RI_COUNT);
    // instruction writes stall while the holding register is full.
    assign pready  = access && !(pwrite && (paddr == REG_INSTR) && hold_full);
    assign pslverr = access && !mapped;

    assign instr_wr  = pready && pwrite && (paddr == REG_INSTR);
    assign count_clr = pready && pwrite && (paddr == REG_RI_COUNT);

    // ****************************************
    // holding register.
    always_ff @(posedge clk) begin
        if (rst) begin
            hold_full <= 1'b0;
        end else if (instr_wr) begin
            hold_full <= 1'b1;
        end else if (in_valid && in_ready) begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr) begin
            hold_word <= pwdata;
        end
    end

    assign in_valid = hold_full;
    assign in_word  = hold_word;

    // reserved count, saturating.
    always_ff @(posedge clk) begin
        if (rst || count_clr) begin
            ri_count <= '0;
        end else if (ri_pop && (ri_count != '1)) begin
            ri_count <= ri_count + 1'b1;
        end
    end

    always_comb begin
        case (paddr)
            REG_INSTR:    prdata = hold_word;
            REG_STATUS:   prdata = {30'b0, queue_nonempty, hold_full};
            REG_RI_COUNT: prdata = ri_count;
            default:      prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder
    import isa_pkg::*;
    import dcu_pkg::*;
(
    input  word_t          instr_word,
    output logic           exception_ri,
    output decoded_instr_t instr
);
    op_t         opcode;
    func_t       func;
    regimm_t     rt_sel;
    logic        r_type;
    decoded_op_t op;
    control_t    ctl;

    assign opcode = op_t'(instr_word[31:26]);
    assign func   = func_t'(instr_word[5:0]);
    assign rt_sel = regimm_t'(instr_word[20:16]);
    assign r_type = (opcode == OP_RT);

    // ****************************************
    // operation select.
    always_comb begin
        op = RESERVED;
        case (opcode)
            OP_RT: begin
                case (func)
                    F_ADD:   op = ADD;
                    F_ADDU:  op = ADDU;
                    F_SUB:   op = SUB;
                    F_SUBU:  op = SUBU;
                    F_SLT:   op = SLT;
                    F_SLTU:  op = SLTU;
                    F_AND:   op = AND;
                    F_OR:    op = OR;
                    F_XOR:   op = XOR;
                    F_NOR:   op = NOR;
                    F_SLL:   op = SLL;
                    F_SRL:   op = SRL;
                    F_SRA:   op = SRA;
                    F_SLLV:  op = SLLV;
                    F_SRLV:  op = SRLV;
                    F_SRAV:  op = SRAV;
                    F_JR:    op = JR;
                    F_JALR:  op = JALR;
                    default: op = RESERVED;
                endcase
            end
            OP_REGIMM: begin
                case (rt_sel)
                    B_BLTZ:   op = BLTZ;
                    B_BGEZ:   op = BGEZ;
                    B_BLTZAL: op = BLTZAL;
                    B_BGEZAL: op = BGEZAL;
                    default:  op = RESERVED;
                endcase
            end
            OP_ADDI:  op = ADD;
            OP_ADDIU: op = ADDU;
            OP_SLTI:  op = SLT;
            OP_SLTIU: op = SLTU;
            OP_ANDI:  op = AND;
            OP_ORI:   op = OR;
            OP_XORI:  op = XOR;
            OP_LUI:   op = LUI;
            OP_BEQ:   op = BEQ;
            OP_BNE:   op = BNE;
            OP_BGTZ:  op = BGTZ;
            OP_BLEZ:  op = BLEZ;
            OP_J:     op = J;
            OP_JAL:   op = JAL;
            OP_LB:    op = LB;
            OP_LBU:   op = LBU;
            OP_LH:    op = LH;
            OP_LHU:   op = LHU;
            OP_LW:    op = LW;
            OP_SB:    op = SB;
            OP_SH:    op = SH;
            OP_SW:    op = SW;
            default:  op = RESERVED;
        endcase
    end

    // ****************************************
    // control bundle from the operation.
    always_comb begin
        ctl = '0;
        case (op)
            ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
            SLL, SRL, SRA, SLLV, SRLV, SRAV: begin
                ctl.regwrite    = 1'b1;
                ctl.regdst      = r_type ? RD : RT;
                ctl.alusrc      = r_type ? REGB : IMM;
                ctl.zeroext     = !r_type && (op inside {AND, OR, XOR});
                ctl.shamt_valid = op inside {SLL, SRL, SRA};
            end
            BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ: begin
                ctl.branch   = 1'b1;
                ctl.regwrite = op inside {BGEZAL, BLTZAL};
            end
            J, JAL, JR, JALR: begin
                ctl.jump     = 1'b1;
                ctl.jr       = op inside {JR, JALR};
                ctl.regwrite = op inside {JAL, JALR};
            end
            LB, LBU, LH, LHU, LW: begin
                ctl.regwrite = 1'b1;
                ctl.memtoreg = 1'b1;
                ctl.alusrc   = IMM;
            end
            SB, SH, SW: begin
                ctl.memwrite = 1'b1;
                ctl.alusrc   = IMM;
            end
            default: begin
                ctl = '0;
            end
        endcase

        case (op)
            ADD:               ctl.alufunc = ALU_ADD;
            ADDU:              ctl.alufunc = ALU_ADDU;
            SUB:               ctl.alufunc = ALU_SUB;
            SUBU:              ctl.alufunc = ALU_SUBU;
            SLT:               ctl.alufunc = ALU_SLT;
            SLTU:              ctl.alufunc = ALU_SLTU;
            AND:               ctl.alufunc = ALU_AND;
            OR:                ctl.alufunc = ALU_OR;
            XOR:               ctl.alufunc = ALU_XOR;
            NOR:               ctl.alufunc = ALU_NOR;
            LUI:               ctl.alufunc = ALU_LUI;
            SLL, SLLV:         ctl.alufunc = ALU_SLL;
            SRL, SRLV:         ctl.alufunc = ALU_SRL;
            SRA, SRAV:         ctl.alufunc = ALU_SRA;
            JR, JALR, RESERVED: ctl.alufunc = ALU_PASSA;
            default:           ctl.alufunc = ALU_ADD;
        endcase

        case (op)
            BNE:           ctl.branch_type = T_BNE;
            BGEZ, BGEZAL:  ctl.branch_type = T_BGEZ;
            BLTZ, BLTZAL:  ctl.branch_type = T_BLTZ;
            BGTZ:          ctl.branch_type = T_BGTZ;
            BLEZ:          ctl.branch_type = T_BLEZ;
            default:       ctl.branch_type = T_BEQ;
        endcase
    end

    assign exception_ri = (op == RESERVED);

    assign instr.op  = op;
    assign instr.ctl = ctl;
    assign instr.rs  = instr_word[25:21];
    assign instr.rt  = instr_word[20:16];
    assign instr.rd  = instr_word[15:11];
    // shift amount, then zero-extend, then sign-extend.
    assign instr.imm = ctl.shamt_valid ? {27'b0, instr_word[10:6]} :
                       ctl.zeroext     ? {16'b0, instr_word[15:0]} :
                                         {{16{instr_word[15]}}, instr_word[15:0]};

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import isa_pkg::*;
    import dcu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  word_t in_word,
    dec_if.source dec_out
);
    decoded_instr_t dec_instr;
    logic           dec_ri;

    decoder decoder0 (
        .instr_word   (in_word),
        .exception_ri (dec_ri),
        .instr        (dec_instr)
    );

    // takes a word when empty or when the current result leaves.
    assign in_ready = !dec_out.valid || dec_out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_out.valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            dec_out.valid <= 1'b1;
        end else if (dec_out.ready) begin
            dec_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec_out.instr <= dec_instr;
            dec_out.ri    <= dec_ri;
        end
    end

endmodule

`default_nettype wire

// ==== src/dec_out_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module dec_out_queue
    import dcu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    dec_if.sink            dec_in,
    output logic           dec_valid,
    input  logic           dec_ready,
    output decoded_instr_t dec_instr,
    output logic           dec_ri,
    output logic           ri_pop,
    output logic           queue_nonempty
);
    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(QUEUE_DEPTH);

    decoded_instr_t   instr_mem [QUEUE_DEPTH];
    logic             ri_mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign dec_in.ready   = (count != FULL_COUNT);
    assign queue_nonempty = (count != '0);
    assign dec_valid      = queue_nonempty;
    assign push           = dec_in.valid && dec_in.ready;
    assign pop            = dec_valid && dec_ready;

    // oldest entry sits at the read pointer.
    assign dec_instr = instr_mem[rd_ptr];
    assign dec_ri    = ri_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            instr_mem[wr_ptr] <= dec_in.instr;
            ri_mem[wr_ptr]    <= dec_in.ri;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ri_pop <= 1'b0;
        end else begin
            ri_pop <= pop && dec_ri;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/dcu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcu_top
    import isa_pkg::*;
    import dcu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic [3:0]     paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,
    output logic           pslverr,
    output logic           dec_valid,
    input  logic           dec_ready,
    output decoded_instr_t dec_instr,
    output logic           dec_ri
);
    logic  in_valid;
    logic  in_ready;
    word_t in_word;
    logic  ri_pop;
    logic  queue_nonempty;

    dec_if dec_link ();

    // ****************************************
    // input side.
    apb_instr_port port0 (
        .clk            (clk),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_word        (in_word),
        .ri_pop         (ri_pop),
        .queue_nonempty (queue_nonempty)
    );

    decode_stage stage0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_word  (in_word),
        .dec_out  (dec_link.source)
    );

    // output side.
    dec_out_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .clk            (clk),
        .rst            (rst),
        .dec_in         (dec_link.sink),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_instr      (dec_instr),
        .dec_ri         (dec_ri),
        .ri_pop         (ri_pop),
        .queue_nonempty (queue_nonempty)
    );

endmodule

`default_nettype wire

// ==== verif/dcu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcu_asserts
    import isa_pkg::*;
    import dcu_pkg::*;
(
    input logic           clk,
    input logic           rst,
    input logic           pready,
    input logic           pslverr,
    input logic           dec_valid,
    input logic           dec_ready,
    input decoded_instr_t dec_instr,
    input logic           dec_ri
);
    int assert_fails = 0;

    // ****************************************
    // output held until taken.
    assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_instr) && $stable(dec_ri))
    else begin
        $error("dec_valid or dec_instr changed before dec_ready");
        assert_fails++;
    end

    assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
    else begin
        $error("pslverr high without pready");
        assert_fails++;
    end

    assert property (@(posedge clk) disable iff (rst)
        dec_valid && dec_ri |-> dec_instr.op == RESERVED)
    else begin
        $error("dec_ri high on a non-reserved operation");
        assert_fails++;
    end

endmodule

bind dcu_top dcu_asserts asserts0 (
    .clk       (clk),
    .rst       (rst),
    .pready    (pready),
    .pslverr   (pslverr),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec_instr (dec_instr),
    .dec_ri    (dec_ri)
);

`default_nettype wire

// ==== verif/dcu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcu_tb
    import isa_pkg::*;
    import dcu_pkg::*;
();
    localparam int NUM_WORDS = 400;
    localparam int TIMEOUT   = 2000;

    logic           clk;
    logic           rst;
    logic [3:0]     paddr;
    logic           psel;
    logic           penable;
    logic           pwrite;
    logic [31:0]    pwdata;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;
    logic           dec_valid;
    logic           dec_ready;
    decoded_instr_t dec_instr;
    logic           dec_ri;

    decoded_instr_t exp_q [$];
    logic           exp_ri_q [$];
    int             errors;
    int             checked;
    int             ri_accepted;
    int             reserved_sent;
    int             stall_cycles;
    logic           hold_output;

    // ****************************************
    // encoding tables for stimulus and model.
    logic [5:0] alu_funcs [18] = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV, F_JR, F_JALR,
                                   F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR,
                                   F_SLT, F_SLTU};
    decoded_op_t alu_func_ops [18] = '{SLL, SRL, SRA, SLLV, SRLV, SRAV, JR, JALR,
                                       ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR, SLT, SLTU};

    // immediates 0..7, memory 8..15, flow 16..21.
    logic [5:0] main_opcodes [22] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                      OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
                                      OP_SB, OP_SH, OP_SW, OP_J, OP_JAL, OP_BEQ, OP_BNE,
                                      OP_BLEZ, OP_BGTZ};
    decoded_op_t main_ops [22] = '{ADD, ADDU, SLT, SLTU, AND, OR, XOR, LUI, LB, LH, LW, LBU,
                                   LHU, SB, SH, SW, J, JAL, BEQ, BNE, BLEZ, BGTZ};

    logic [4:0]  regimm_sels [4] = '{B_BLTZ, B_BGEZ, B_BLTZAL, B_BGEZAL};
    decoded_op_t regimm_ops [4]  = '{BLTZ, BGEZ, BLTZAL, BGEZAL};

    // cop0, lwl/lwr/swl/swr and other holes.
    logic [5:0] bad_opcodes [12] = '{6'h10, 6'h11, 6'h12, 6'h13, 6'h14, 6'h18, 6'h1c,
                                     6'h22, 6'h26, 6'h2a, 6'h2e, 6'h3f};
    // syscall, break, hi/lo moves, mult/div.
    logic [5:0] bad_funcs [14] = '{6'h01, 6'h05, 6'h0c, 6'h0d, 6'h10, 6'h11, 6'h12, 6'h13,
                                   6'h18, 6'h19, 6'h1a, 6'h1b, 6'h2c, 6'h3f};
    logic [4:0] bad_sels [8]   = '{5'h02, 5'h03, 5'h08, 5'h09, 5'h0c, 5'h12, 5'h13, 5'h1f};

    dcu_top #(
        .QUEUE_DEPTH (4)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_instr (dec_instr),
        .dec_ri    (dec_ri)
    );

    always #20 clk = ~clk;

    task automatic finish_run();
        $display("checked %0d results, %0d errors, %0d assertion failures",
                 checked, errors, dut0.asserts0.assert_fails);
        if (errors == 0 && dut0.asserts0.assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout: %s", what);
        errors++;
        finish_run();
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ****************************************
    // apb master.
    task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        #2;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        waits   = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (wr && addr == REG_INSTR) begin
                stall_cycles++;
            end
            if (waits > TIMEOUT) begin
                timeout_fail("apb access never saw pready");
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused;
        apb_access(addr, 1'b1, data, unused, err);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
        apb_access(addr, 1'b0, 32'h0, rdata, err);
    endtask

    // ****************************************
    // reference model.
    function automatic decoded_instr_t model_decode(input word_t w);
        decoded_instr_t e;
        logic           r_type;
        e      = '0;
        e.op   = RESERVED;
        r_type = (w[31:26] == OP_RT);
        if (r_type) begin
            for (int i = 0; i < 18; i++) begin
                if (w[5:0] == alu_funcs[i]) e.op = alu_func_ops[i];
            end
        end else if (w[31:26] == OP_REGIMM) begin
            for (int i = 0; i < 4; i++) begin
                if (w[20:16] == regimm_sels[i]) e.op = regimm_ops[i];
            end
        end else begin
            for (int i = 0; i < 22; i++) begin
                if (w[31:26] == main_opcodes[i]) e.op = main_ops[i];
            end
        end

        if (e.op inside {ADD, ADDU, SUB, SUBU, SLT, SLTU, AND, OR, XOR, NOR, LUI,
                         SLL, SRL, SRA, SLLV, SRLV, SRAV}) begin
            e.ctl.regwrite    = 1'b1;
            e.ctl.regdst      = r_type ? RD : RT;
            e.ctl.alusrc      = r_type ? REGB : IMM;
            e.ctl.zeroext     = !r_type && (e.op inside {AND, OR, XOR});
            e.ctl.shamt_valid = e.op inside {SLL, SRL, SRA};
        end else if (e.op inside {BEQ, BNE, BGEZ, BLTZ, BGEZAL, BLTZAL, BGTZ, BLEZ}) begin
            e.ctl.branch   = 1'b1;
            e.ctl.regwrite = e.op inside {BGEZAL, BLTZAL};
        end else if (e.op inside {J, JAL, JR, JALR}) begin
            e.ctl.jump     = 1'b1;
            e.ctl.jr       = e.op inside {JR, JALR};
            e.ctl.regwrite = e.op inside {JAL, JALR};
        end else if (e.op inside {LB, LBU, LH, LHU, LW}) begin
            e.ctl.regwrite = 1'b1;
            e.ctl.memtoreg = 1'b1;
            e.ctl.alusrc   = IMM;
        end else if (e.op inside {SB, SH, SW}) begin
            e.ctl.memwrite = 1'b1;
            e.ctl.alusrc   = IMM;
        end

        case (e.op)
            SUB:                e.ctl.alufunc = ALU_SUB;
            SUBU:               e.ctl.alufunc = ALU_SUBU;
            ADDU:               e.ctl.alufunc = ALU_ADDU;
            SLT:                e.ctl.alufunc = ALU_SLT;
            SLTU:               e.ctl.alufunc = ALU_SLTU;
            AND:                e.ctl.alufunc = ALU_AND;
            OR:                 e.ctl.alufunc = ALU_OR;
            XOR:                e.ctl.alufunc = ALU_XOR;
            NOR:                e.ctl.alufunc = ALU_NOR;
            LUI:                e.ctl.alufunc = ALU_LUI;
            SLL, SLLV:          e.ctl.alufunc = ALU_SLL;
            SRL, SRLV:          e.ctl.alufunc = ALU_SRL;
            SRA, SRAV:          e.ctl.alufunc = ALU_SRA;
            JR, JALR, RESERVED: e.ctl.alufunc = ALU_PASSA;
            default:            e.ctl.alufunc = ALU_ADD;
        endcase

        case (e.op)
            BNE:          e.ctl.branch_type = T_BNE;
            BGEZ, BGEZAL: e.ctl.branch_type = T_BGEZ;
            BLTZ, BLTZAL: e.ctl.branch_type = T_BLTZ;
            BGTZ:         e.ctl.branch_type = T_BGTZ;
            BLEZ:         e.ctl.branch_type = T_BLEZ;
            default:      e.ctl.branch_type = T_BEQ;
        endcase

        e.rs = w[25:21];
        e.rt = w[20:16];
        e.rd = w[15:11];
        if (e.ctl.shamt_valid) begin
            e.imm = 32'(w[10:6]);
        end else if (e.ctl.zeroext) begin
            e.imm = 32'(w[15:0]);
        end else begin
            e.imm = 32'(signed'(w[15:0]));
        end
        return e;
    endfunction

    function automatic word_t random_word();
        word_t w;
        int    kind;
        w    = $urandom();
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1: begin
                w[31:26] = OP_RT;
                w[5:0]   = alu_funcs[$urandom_range(0, 17)];
            end
            2: w[31:26] = main_opcodes[$urandom_range(0, 7)];
            3: w[31:26] = main_opcodes[$urandom_range(8, 15)];
            4: w[31:26] = main_opcodes[$urandom_range(16, 21)];
            5: begin
                w[31:26] = OP_REGIMM;
                w[20:16] = regimm_sels[$urandom_range(0, 3)];
            end
            6: w[31:26] = bad_opcodes[$urandom_range(0, 11)];
            7: begin
                w[31:26] = OP_RT;
                w[5:0]   = bad_funcs[$urandom_range(0, 13)];
            end
            8: begin
                w[31:26] = OP_REGIMM;
                w[20:16] = bad_sels[$urandom_range(0, 7)];
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic send_word(input word_t w);
        decoded_instr_t e;
        logic           err;
        e = model_decode(w);
        exp_q.push_back(e);
        exp_ri_q.push_back(e.op == RESERVED);
        if (e.op == RESERVED) begin
            reserved_sent++;
        end
        apb_write(REG_INSTR, w, err);
        check_field("pslverr", err, 1'b0);
    endtask

    // ****************************************
    // output consumer.
    initial begin : consumer
        int             stall_left;
        decoded_instr_t exp;
        logic           exp_ri;
        stall_left = 0;
        forever begin
            @(negedge clk);
            if (!rst && dec_valid && dec_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output accepted with no word outstanding");
                    errors++;
                end else begin
                    exp    = exp_q.pop_front();
                    exp_ri = exp_ri_q.pop_front();
                    check_field("dec_instr.op", dec_instr.op, exp.op);
                    check_field("dec_instr.ctl", dec_instr.ctl, exp.ctl);
                    check_field("dec_instr.rs", dec_instr.rs, exp.rs);
                    check_field("dec_instr.rt", dec_instr.rt, exp.rt);
                    check_field("dec_instr.rd", dec_instr.rd, exp.rd);
                    check_field("dec_instr.imm", dec_instr.imm, exp.imm);
                    check_field("dec_ri", dec_ri, exp_ri);
                    if (exp_ri) ri_accepted++;
                    checked++;
                end
            end
            @(posedge clk);
            #2;
            // long stalls let back-pressure reach the apb port.
            if (hold_output) begin
                dec_ready = 1'b0;
            end else if (stall_left > 0) begin
                dec_ready = 1'b0;
                stall_left--;
            end else if ($urandom_range(0, 39) == 0) begin
                dec_ready  = 1'b0;
                stall_left = $urandom_range(20, 60);
            end else begin
                dec_ready = 1'($urandom_range(0, 1));
            end
        end
    end

    initial begin : main
        logic [31:0] rdata;
        logic        err;
        int          waits;
        void'($urandom(32'hdf2b));
        clk           = 1'b0;
        rst           = 1'b1;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        dec_ready     = 1'b0;
        hold_output   = 1'b0;
        errors        = 0;
        checked       = 0;
        ri_accepted   = 0;
        reserved_sent = 0;
        stall_cycles  = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        check_field("dec_valid", dec_valid, 1'b0);
        check_field("pready", pready, 1'b0);
        check_field("pslverr", pslverr, 1'b0);
        apb_read(REG_RI_COUNT, rdata, err);
        check_field("prdata", rdata, 32'h0);

        // a waiting result shows in the status register.
        hold_output = 1'b1;
        send_word(32'h2002_0005);
        waits = 0;
        while (!dec_valid) begin
            waits++;
            if (waits > TIMEOUT) begin
                timeout_fail("first result never reached dec_valid");
            end
            @(negedge clk);
        end
        apb_read(REG_STATUS, rdata, err);
        check_field("prdata", rdata[1], 1'b1);
        hold_output = 1'b0;

        for (int i = 0; i < NUM_WORDS; i++) begin
            send_word(random_word());
        end

        waits = 0;
        while (exp_q.size() != 0) begin
            waits++;
            if (waits > TIMEOUT) begin
                timeout_fail("outputs did not drain");
            end
            @(posedge clk);
        end
        repeat (3) @(posedge clk);

        apb_read(REG_STATUS, rdata, err);
        check_field("prdata", rdata, 32'h0);
        apb_read(REG_RI_COUNT, rdata, err);
        check_field("prdata", rdata, ri_accepted);
        apb_write(REG_RI_COUNT, 32'hffff_ffff, err);
        apb_read(REG_RI_COUNT, rdata, err);
        check_field("prdata", rdata, 32'h0);
        apb_read(4'hc, rdata, err);
        check_field("pslverr", err, 1'b1);
        apb_write(4'h2, 32'h1234_5678, err);
        check_field("pslverr", err, 1'b1);

        if (stall_cycles == 0) begin
            $display("instruction writes never stalled on a full holding register");
            errors++;
        end
        if (reserved_sent == 0) begin
            $display("no reserved encoding was sent");
            errors++;
        end
        finish_run();
    end

endmodule

`default_nettype wire

// ==== dcu_top.f ====
src/isa_pkg.sv
src/dcu_pkg.sv
src/dec_if.sv
src/apb_instr_port.sv
src/decoder.sv
src/decode_stage.sv
src/dec_out_queue.sv
src/dcu_top.sv
verif/dcu_asserts.sv
verif/dcu_tb.sv

// ==== Bender.yml ====
package:
  name: dcu

sources:
  - files:
      - src/isa_pkg.sv
      - src/dcu_pkg.sv
      - src/dec_if.sv
      - src/apb_instr_port.sv
      - src/decoder.sv
      - src/decode_stage.sv
      - src/dec_out_queue.sv
      - src/dcu_top.sv
  - target: test
    files:
      - verif/dcu_asserts.sv
      - verif/dcu_tb.sv
